/* design/conv_params.svh */
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

`define CONV_BITWIDTH     16
`define CONV_ADDR_WIDTH   20

// input map size
`define CONV_I_WIDTH      8
`define CONV_I_HEIGHT     6

`define CONV_KERNEL_W     3
`define CONV_KERNEL_H     3

`define CONV_I_KERNEL_N   2     // input channels
`define CONV_O_KERNEL_N   2     // output kernels

// non-overlapping sram regions
`define CONV_DATA_ADDR    20'h00000
`define CONV_WEIGHT_ADDR  20'h10000
`define CONV_OUTPUT_ADDR  20'h20000

`endif

/* design/conv_pkg.sv */
package conv_pkg;

    typedef enum logic [2:0] {
        S_IDLE        = 3'd0,
        S_NEW_OUTPUT  = 3'd1,
        S_LOAD_KERNEL = 3'd2,
        S_LOAD_LINES  = 3'd3,
        S_CONV        = 3'd4,
        S_STORE       = 3'd5,
        S_DONE        = 3'd6
    } conv_state_e;

endpackage

/* design/kern_if.sv */
`timescale 1ns/1ps
`include "conv_params.svh"

interface kern_if (
    input logic i_clk
);

    localparam int BW = `CONV_BITWIDTH;
    localparam int KH = `CONV_KERNEL_H;

    logic                  loading_weight;  // one strobe per weight column
    logic [KH-1:0][BW-1:0] weight_col;
    logic                  bias_load;
    logic [BW-1:0]         bias;
    logic                  shift;           // push data_col into window
    logic [KH-1:0][BW-1:0] data_col;        // index KH-1 is the newest row
    logic [BW-1:0]         result;

    modport ctrl (
        input  i_clk, result,
        output loading_weight, weight_col, bias_load, bias, shift, data_col
    );

    modport kern (
        input  i_clk, loading_weight, weight_col, bias_load, bias, shift, data_col,
        output result
    );

endinterface

/* design/line_buffer.sv */
`timescale 1ns/1ps
`include "conv_params.svh"

module line_buffer #(
    parameter int linelen = 8
) (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_enable,
    input  logic [`CONV_BITWIDTH-1:0] i_data,
    output logic [`CONV_BITWIDTH-1:0] o_data
);

    localparam int bitwidth = `CONV_BITWIDTH;

    logic [linelen-1:0][bitwidth-1:0] line_r;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            line_r <= '0;
        end else if (i_enable) begin
            line_r[0] <= i_data;
            for (int k = 1; k < linelen; k++) begin
                line_r[k] <= line_r[k-1];
            end
        end
    end

    assign o_data = line_r[linelen-1];  // oldest word

endmodule

/* design/conv_kernel.sv */
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_kernel (
    input logic  i_clk,
    input logic  i_rst,
    kern_if.kern kern
);

    localparam int BW = `CONV_BITWIDTH;
    localparam int KW = `CONV_KERNEL_W;
    localparam int KH = `CONV_KERNEL_H;

    // column 0 is the leftmost, KW-1 the most recently loaded
    logic [KW-1:0][KH-1:0][BW-1:0] weight_r;
    logic [KW-1:0][KH-1:0][BW-1:0] window_r;
    logic [BW-1:0]                 bias_r;
    logic [BW-1:0]                 acc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            weight_r <= '0;
            window_r <= '0;
            bias_r   <= '0;
        end else begin
            if (kern.loading_weight) begin
                for (int c = 0; c < KW-1; c++) begin
                    weight_r[c] <= weight_r[c+1];
                end
                weight_r[KW-1] <= kern.weight_col;
            end

            if (kern.bias_load) begin
                bias_r <= kern.bias;
            end

            // sliding window moves by one column per shift
            if (kern.shift) begin
                for (int c = 0; c < KW-1; c++) begin
                    window_r[c] <= window_r[c+1];
                end
                window_r[KW-1] <= kern.data_col;
            end
        end
    end

    // dot product wraps at 16 bits
    always_comb begin
        acc = bias_r;
        for (int c = 0; c < KW; c++) begin
            for (int r = 0; r < KH; r++) begin
                acc = acc + window_r[c][r] * weight_r[c][r];
            end
        end
    end

    assign kern.result = acc;

endmodule

/* design/convolution.sv */
`timescale 1ns/1ps
`include "conv_params.svh"

module convolution
    import conv_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_enable,
    output logic                        o_finished,
    output logic [`CONV_ADDR_WIDTH-1:0] o_sram_addr,
    output logic                        o_sram_wren,
    output logic [`CONV_BITWIDTH-1:0]   o_sram_wdata,
    input  logic [`CONV_BITWIDTH-1:0]   i_sram_rdata,
    kern_if.ctrl                        kern
);

    localparam int BW    = `CONV_BITWIDTH;
    localparam int AW    = `CONV_ADDR_WIDTH;
    localparam int W     = `CONV_I_WIDTH;
    localparam int H     = `CONV_I_HEIGHT;
    localparam int KW    = `CONV_KERNEL_W;
    localparam int KH    = `CONV_KERNEL_H;
    localparam int IKN   = `CONV_I_KERNEL_N;
    localparam int OKN   = `CONV_O_KERNEL_N;
    localparam int OH    = H - KH + 1;
    localparam int OW    = W - KW + 1;
    localparam int KSZ   = KH * KW + 1;  // bias plus weights
    localparam int OMAP  = OH * OW;
    localparam int PAIRS = IKN * OKN;
    localparam int PW    = $clog2(PAIRS + 1);

    conv_state_e state_r, state_w;

    logic [$clog2(IKN+1)-1:0]  ich_r;
    logic [$clog2(OKN+1)-1:0]  och_r;
    logic [PW-1:0]             pair_idx;
    logic                      last_pair;
    logic [$clog2(KSZ+1)-1:0]  ld_cnt_r;
    logic [$clog2(KH+1)-1:0]   wrow_r;
    logic                      col_ready_r;
    logic [KH-1:0][BW-1:0]     weight_buf_r;
    logic [$clog2(H+1)-1:0]    rd_row_r, pix_row_r;
    logic [$clog2(W+1)-1:0]    rd_col_r, pix_col_r;
    logic                      rd_issue;
    logic                      pix_valid_r;
    logic                      res_valid_r;
    logic [1:0]                tail_r;
    logic [$clog2(OMAP+1)-1:0] st_cnt_r;
    logic [KH-2:0][BW-1:0]     ln_out;
    logic                      out_buf_en;

    function automatic logic [AW-1:0] data_addr(input int unsigned p, r, c);
        return AW'(`CONV_DATA_ADDR) + AW'((p * H + r) * W + c);
    endfunction

    function automatic logic [AW-1:0] weight_addr(input int unsigned p, ofs);
        return AW'(`CONV_WEIGHT_ADDR) + AW'(p * KSZ + ofs);
    endfunction

    function automatic logic [AW-1:0] out_addr(input int unsigned p, idx);
        return AW'(`CONV_OUTPUT_ADDR) + AW'(p * OMAP + idx);
    endfunction

    assign pair_idx  = PW'(ich_r * OKN + och_r);
    assign last_pair = (ich_r == IKN-1) && (och_r == OKN-1);
    assign rd_issue  = (state_r == S_LOAD_LINES) || (state_r == S_CONV && tail_r == 2'd0);

    always_comb begin
        state_w = state_r;
        case (state_r)
            S_IDLE, S_DONE: begin
                if (i_enable) begin
                    state_w = S_NEW_OUTPUT;
                end
            end
            S_NEW_OUTPUT: state_w = S_LOAD_KERNEL;
            S_LOAD_KERNEL: begin
                if (ld_cnt_r == KSZ) begin
                    state_w = S_LOAD_LINES;
                end
            end
            S_LOAD_LINES: begin
                // first KH-1 rows only fill the line buffers
                if (rd_row_r == KH-2 && rd_col_r == W-1) begin
                    state_w = S_CONV;
                end
            end
            S_CONV: begin
                if (tail_r == 2'd2) begin
                    state_w = S_STORE;
                end
            end
            S_STORE: begin
                if (st_cnt_r == OMAP-1) begin
                    state_w = last_pair ? S_DONE : S_NEW_OUTPUT;
                end
            end
            default: state_w = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_r     <= S_IDLE;
            ich_r       <= '0;
            och_r       <= '0;
            ld_cnt_r    <= '0;
            wrow_r      <= '0;
            col_ready_r <= 1'b0;
            rd_row_r    <= '0;
            rd_col_r    <= '0;
            tail_r      <= '0;
            st_cnt_r    <= '0;
        end else begin
            state_r     <= state_w;
            col_ready_r <= 1'b0;

            if (rd_issue) begin
                if (rd_col_r == W-1) begin
                    rd_col_r <= '0;
                    rd_row_r <= rd_row_r + 1'b1;
                end else begin
                    rd_col_r <= rd_col_r + 1'b1;
                end
            end

            case (state_r)
                S_NEW_OUTPUT: begin
                    ld_cnt_r <= '0;
                    wrow_r   <= '0;
                    rd_row_r <= '0;
                    rd_col_r <= '0;
                    tail_r   <= '0;
                    st_cnt_r <= '0;
                end
                S_LOAD_KERNEL: begin
                    ld_cnt_r <= ld_cnt_r + 1'b1;
                    if (ld_cnt_r >= 2) begin  // weight words
                        col_ready_r <= (wrow_r == KH-1);
                        wrow_r      <= (wrow_r == KH-1) ? '0 : wrow_r + 1'b1;
                    end
                end
                S_CONV: begin
                    if (tail_r != 2'd0) begin
                        tail_r <= tail_r + 1'b1;
                    end else if (rd_row_r == H-1 && rd_col_r == W-1) begin
                        tail_r <= 2'd1;
                    end
                end
                S_STORE: begin
                    st_cnt_r <= st_cnt_r + 1'b1;
                    if (st_cnt_r == OMAP-1) begin
                        if (och_r == OKN-1) begin
                            och_r <= '0;
                            ich_r <= (ich_r == IKN-1) ? '0 : ich_r + 1'b1;
                        end else begin
                            och_r <= och_r + 1'b1;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == S_LOAD_KERNEL && ld_cnt_r >= 2) begin
            weight_buf_r[wrow_r] <= i_sram_rdata;
        end
    end

    // position of the pixel arriving this cycle
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pix_valid_r <= 1'b0;
            pix_row_r   <= '0;
            pix_col_r   <= '0;
            res_valid_r <= 1'b0;
        end else begin
            pix_valid_r <= rd_issue;
            pix_row_r   <= rd_row_r;
            pix_col_r   <= rd_col_r;
            res_valid_r <= pix_valid_r && (pix_row_r >= KH-1) && (pix_col_r >= KW-1);
        end
    end

    genvar gv_i;
    generate
        for (gv_i = 0; gv_i < KH-1; gv_i++) begin : g_ln_buf
            logic [BW-1:0] ln_in;

            if (gv_i == 0) begin : g_head
                assign ln_in = i_sram_rdata;
            end else begin : g_link
                assign ln_in = ln_out[gv_i-1];
            end

            line_buffer #(
                .linelen(W)
            ) u_lb (
                .i_clk    (i_clk),
                .i_rst    (i_rst),
                .i_enable (pix_valid_r),
                .i_data   (ln_in),
                .o_data   (ln_out[gv_i])
            );
        end
    endgenerate

    assign kern.loading_weight = col_ready_r;
    assign kern.weight_col     = weight_buf_r;
    assign kern.bias_load      = (state_r == S_LOAD_KERNEL) && (ld_cnt_r == 1);
    assign kern.bias           = i_sram_rdata;
    assign kern.shift          = pix_valid_r;

    always_comb begin
        kern.data_col[KH-1] = i_sram_rdata;
        for (int r = 0; r < KH-1; r++) begin
            kern.data_col[r] = ln_out[KH-2-r];  // older rows come out deeper in the chain
        end
    end

    // filled by results, drained during store
    assign out_buf_en = res_valid_r || (state_r == S_STORE);

    line_buffer #(
        .linelen(OMAP)
    ) u_out_buf (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_enable (out_buf_en),
        .i_data   (kern.result),
        .o_data   (o_sram_wdata)
    );

    always_comb begin
        case (state_r)
            S_LOAD_KERNEL:        o_sram_addr = weight_addr(pair_idx, ld_cnt_r);
            S_LOAD_LINES, S_CONV: o_sram_addr = data_addr(pair_idx, rd_row_r, rd_col_r);
            S_STORE:              o_sram_addr = out_addr(pair_idx, st_cnt_r);
            default:              o_sram_addr = '0;
        endcase
    end

    assign o_sram_wren = (state_r == S_STORE);
    assign o_finished  = (state_r == S_DONE);

endmodule

/* design/conv_top.sv */
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_top (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_enable,
    output logic                        o_finished,
    output logic [`CONV_ADDR_WIDTH-1:0] o_sram_addr,
    output logic                        o_sram_wren,
    output logic [`CONV_BITWIDTH-1:0]   o_sram_wdata,
    input  logic [`CONV_BITWIDTH-1:0]   i_sram_rdata
);

    kern_if u_kif (
        .i_clk (i_clk)
    );

    convolution u_conv (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_enable     (i_enable),
        .o_finished   (o_finished),
        .o_sram_addr  (o_sram_addr),
        .o_sram_wren  (o_sram_wren),
        .o_sram_wdata (o_sram_wdata),
        .i_sram_rdata (i_sram_rdata),
        .kern         (u_kif.ctrl)
    );

    // external kernel, fed by the controller
    conv_kernel u_kernel (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .kern  (u_kif.kern)
    );

endmodule

/* tests/conv_properties.sv */
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_props
    import conv_pkg::*;
(
    input logic                        i_clk,
    input logic                        i_rst,
    input conv_state_e                 i_state,
    input logic                        i_finished,
    input logic                        i_sram_wren,
    input logic [`CONV_ADDR_WIDTH-1:0] i_sram_addr,
    input logic                        i_loading_weight,
    input logic                        i_bias_load,
    input logic                        i_shift
);

    localparam int AW    = `CONV_ADDR_WIDTH;
    localparam int OMAP  = (`CONV_I_HEIGHT - `CONV_KERNEL_H + 1)
                         * (`CONV_I_WIDTH - `CONV_KERNEL_W + 1);
    localparam int PAIRS = `CONV_I_KERNEL_N * `CONV_O_KERNEL_N;
    localparam logic [AW-1:0] OUT_LO = `CONV_OUTPUT_ADDR;
    localparam logic [AW-1:0] OUT_HI = OUT_LO + AW'(PAIRS * OMAP);  // one past the last output

    int unsigned fail_cnt = 0;  // read by the testbench

    a_wren_in_store: assert property (@(posedge i_clk) disable iff (i_rst)
        i_sram_wren |-> (i_state == S_STORE))
        else begin
            fail_cnt++;
            $error("sram write strobe outside the store state");
        end

    a_wr_addr_range: assert property (@(posedge i_clk) disable iff (i_rst)
        i_sram_wren |-> (i_sram_addr >= OUT_LO && i_sram_addr < OUT_HI))
        else begin
            fail_cnt++;
            $error("sram write address outside the output region");
        end

    a_finished_in_done: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_state != S_DONE) |-> !i_finished)
        else begin
            fail_cnt++;
            $error("finished flag high outside the done state");
        end

    // first cycle out of reset
    a_quiet_after_reset: assert property (@(posedge i_clk)
        $fell(i_rst) |-> !(i_loading_weight || i_bias_load || i_shift))
        else begin
            fail_cnt++;
            $error("kernel strobe active right after reset");
        end

endmodule

bind conv_top conv_props u_props (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_state          (u_conv.state_r),
    .i_finished       (o_finished),
    .i_sram_wren      (o_sram_wren),
    .i_sram_addr      (o_sram_addr),
    .i_loading_weight (u_kif.loading_weight),
    .i_bias_load      (u_kif.bias_load),
    .i_shift          (u_kif.shift)
);

/* tests/conv_tb.sv */
`timescale 1ns/1ps
`include "conv_params.svh"

module conv_tb;

    localparam int BW    = `CONV_BITWIDTH;
    localparam int AW    = `CONV_ADDR_WIDTH;
    localparam int W     = `CONV_I_WIDTH;
    localparam int H     = `CONV_I_HEIGHT;
    localparam int KW    = `CONV_KERNEL_W;
    localparam int KH    = `CONV_KERNEL_H;
    localparam int IKN   = `CONV_I_KERNEL_N;
    localparam int OKN   = `CONV_O_KERNEL_N;
    localparam int OH    = H - KH + 1;
    localparam int OW    = W - KW + 1;
    localparam int PAIRS = IKN * OKN;

    // new output, kernel load, line streaming with tail, store
    localparam int PAIR_CYCLES    = 1 + (1 + KH * KW + 1) + (W * H + 2) + OH * OW;
    localparam int NUM_RUNS       = 4;
    localparam int TIMEOUT_CYCLES = NUM_RUNS * 2 * PAIR_CYCLES * PAIRS;

    localparam logic [31:0] SEED = 32'h52c5_0260;

    // what each run expects at the outputs
    localparam int CHECK_REF    = 0;
    localparam int CHECK_BIAS   = 1;
    localparam int CHECK_CENTRE = 2;

    logic          clk;
    logic          rst;
    logic          en;
    logic          finished;
    logic [AW-1:0] sram_addr;
    logic          sram_wren;
    logic [BW-1:0] sram_wdata;
    logic [BW-1:0] sram_rdata;
    logic [BW-1:0] rd_word;

    logic [BW-1:0] mem [logic [AW-1:0]];
    logic [BW-1:0] shadow [logic [AW-1:0]];  // input and weight words as written
    int unsigned   cycle_cnt;

    conv_top i_dut (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_enable     (en),
        .o_finished   (finished),
        .o_sram_addr  (sram_addr),
        .o_sram_wren  (sram_wren),
        .o_sram_wdata (sram_wdata),
        .i_sram_rdata (sram_rdata)
    );

    always #20 clk = ~clk;

    function automatic logic [AW-1:0] data_loc(input int i, o, r, c);
        return AW'(`CONV_DATA_ADDR) + AW'(((i * OKN + o) * H + r) * W + c);
    endfunction

    function automatic logic [AW-1:0] weight_loc(input int i, o, ofs);
        return AW'(`CONV_WEIGHT_ADDR) + AW'((i * OKN + o) * (KH * KW + 1) + ofs);
    endfunction

    function automatic logic [AW-1:0] out_loc(input int i, o, r, c);
        return AW'(`CONV_OUTPUT_ADDR) + AW'(((i * OKN + o) * OH + r) * OW + c);
    endfunction

    function automatic logic in_output_region(input logic [AW-1:0] a);
        return (a >= AW'(`CONV_OUTPUT_ADDR))
            && (a < AW'(`CONV_OUTPUT_ADDR) + AW'(PAIRS * OH * OW));
    endfunction

    function automatic logic [BW-1:0] read_word(input logic [AW-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return BW'(a ^ (a >> BW) ^ 32'h5a3);  // never-written words
    endfunction

    function automatic logic [BW-1:0] small_random();
        logic [31:0] v;
        v = $urandom;
        return {{(BW-8){v[7]}}, v[7:0]};  // signed 8-bit range
    endfunction

    // bias plus window dot product wrapped to BW bits
    function automatic logic [BW-1:0] conv_ref(input int i, o, r, c);
        logic [BW-1:0] acc;
        logic [BW-1:0] wt;
        logic [BW-1:0] px;
        acc = shadow[weight_loc(i, o, 0)];
        for (int kc = 0; kc < KW; kc++) begin
            for (int kr = 0; kr < KH; kr++) begin
                wt  = shadow[weight_loc(i, o, 1 + kc * KH + kr)];
                px  = shadow[data_loc(i, o, r + kr, c + kc)];
                acc = acc + wt * px;
            end
        end
        return acc;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, exp);
        if (got !== exp) begin
            $display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    // sram model with one-cycle read latency
    always @(posedge clk) begin
        if (rst) begin
            rd_word = '0;
        end else begin
            if (sram_wren === 1'b1) begin
                if (!in_output_region(sram_addr)) begin
                    abort_run("sram write landed outside the output region");
                end
                mem[sram_addr] = sram_wdata;
            end
            rd_word = read_word(sram_addr);
        end
        #2;
        sram_rdata = rd_word;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            abort_run("timeout: the engine did not finish within the cycle limit");
        end
    end

    // an assertion failure ends the run at once
    always @(negedge clk) begin
        if (i_dut.u_props.fail_cnt != 0) begin
            abort_run("an assertion on the DUT failed during the run");
        end
    end

    task automatic put_word(input logic [AW-1:0] a, input logic [BW-1:0] v);
        mem[a]    = v;
        shadow[a] = v;
    endtask

    task automatic fill_maps(input int mode);
        logic [BW-1:0] w;
        for (int i = 0; i < IKN; i++) begin
            for (int o = 0; o < OKN; o++) begin
                for (int r = 0; r < H; r++) begin
                    for (int c = 0; c < W; c++) begin
                        put_word(data_loc(i, o, r, c), small_random());
                    end
                end
                case (mode)
                    CHECK_REF:  put_word(weight_loc(i, o, 0), small_random());
                    CHECK_BIAS: put_word(weight_loc(i, o, 0), BW'($urandom));
                    default:    put_word(weight_loc(i, o, 0), '0);
                endcase
                for (int ofs = 1; ofs <= KH * KW; ofs++) begin
                    if (mode == CHECK_REF) begin
                        w = small_random();
                    end else if (mode == CHECK_CENTRE) begin
                        w = ((ofs - 1) == (KW / 2) * KH + KH / 2) ? BW'(1) : '0;
                    end else begin
                        w = '0;
                    end
                    put_word(weight_loc(i, o, ofs), w);
                end
                for (int r = 0; r < OH; r++) begin
                    for (int c = 0; c < OW; c++) begin
                        mem.delete(out_loc(i, o, r, c));  // no stale results
                    end
                end
            end
        end
    endtask

    task automatic pulse_enable();
        @(posedge clk);
        #2 en = 1'b1;
        @(posedge clk);
        #2 en = 1'b0;
    endtask

    task automatic wait_finished();
        while (finished !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic compare_outputs(input int mode);
        logic [BW-1:0] exp;
        for (int i = 0; i < IKN; i++) begin
            for (int o = 0; o < OKN; o++) begin
                for (int r = 0; r < OH; r++) begin
                    for (int c = 0; c < OW; c++) begin
                        case (mode)
                            CHECK_BIAS:   exp = shadow[weight_loc(i, o, 0)];
                            CHECK_CENTRE: exp = shadow[data_loc(i, o, r + KH / 2, c + KW / 2)];
                            default:      exp = conv_ref(i, o, r, c);
                        endcase
                        check_value($sformatf("out[%0d][%0d][%0d][%0d]", i, o, r, c),
                                    read_word(out_loc(i, o, r, c)), exp);
                    end
                end
            end
        end
    endtask

    task automatic check_inputs_intact();
        foreach (shadow[a]) begin
            check_value($sformatf("sram[0x%0h]", a), read_word(a), shadow[a]);
        end
    endtask

    task automatic run_pass(input int mode);
        fill_maps(mode);
        pulse_enable();
        wait_finished();
        compare_outputs(mode);
        check_inputs_intact();
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        en         = 1'b0;
        sram_rdata = '0;
        rd_word    = '0;
        cycle_cnt  = 0;
        void'($urandom(SEED));

        repeat (8) @(posedge clk);
        #2 rst = 1'b0;

        // idle until enabled
        repeat (4) begin
            @(negedge clk);
            check_value("o_finished", finished, 0);
            check_value("o_sram_wren", sram_wren, 0);
        end

        run_pass(CHECK_REF);
        run_pass(CHECK_BIAS);
        run_pass(CHECK_CENTRE);
        run_pass(CHECK_REF);  // restart from done with fresh data

        if (i_dut.u_props.fail_cnt == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("an assertion on the DUT failed");
        end
    end

endmodule

/* sources.f */
+incdir+design
design/conv_pkg.sv
design/kern_if.sv
design/line_buffer.sv
design/conv_kernel.sv
design/convolution.sv
design/conv_top.sv
tests/conv_properties.sv
tests/conv_tb.sv
